// File: compile.f
+incdir+logic
logic/load_pkg.sv
logic/load_decode.sv
logic/load_issue.sv
logic/load_buffer.sv
logic/load_align.sv
logic/load_unit.sv
verif/tb_clock.sv
verif/load_unit_tb.sv

// File: logic/load_align.sv
// load_align: realigns response data by byte offset and sign or zero extends it by size
`timescale 1ns/1ps
`include "load_defines.svh"

module load_align (
  input  logic [`LOAD_XLEN-1:0]  rdata_i,
  input  load_pkg::ldbuf_entry_t entry_i,
  output logic [`LOAD_XLEN-1:0]  result_o
);

  logic [`LOAD_XLEN-1:0]        shifted;
  logic [`LOAD_XLEN_BYTES-1:0]  byte_msbs;
  logic [`LOAD_OFFSET_BITS-1:0] span;
  logic [`LOAD_OFFSET_BITS-1:0] top_byte;
  logic                         sign_bit;

  // ------------------------------------------------------------
  // realignment
  // ------------------------------------------------------------

  // the accessed field is moved down to bit zero
  assign shifted = rdata_i >> {entry_i.offset, 3'b000};

  // ------------------------------------------------------------
  // sign bit
  // ------------------------------------------------------------

  // the top bit of every byte lane of the unshifted word
  for (genvar i = 0; i < `LOAD_XLEN_BYTES; i++) begin : gen_byte_msb
    assign byte_msbs[i] = rdata_i[8*i+7];
  end

  // distance from the lowest to the highest byte of the field
  always_comb begin
    case (entry_i.size)
      load_pkg::SIZE_BYTE: span = 3'd0;
      load_pkg::SIZE_HALF: span = 3'd1;
      load_pkg::SIZE_WORD: span = 3'd3;
      default:             span = 3'd7;
    endcase
  end

  // aligned fields never wrap past the top of the word
  assign top_byte = entry_i.offset + span;
  // the sign is picked beside the shifter instead of after it, which keeps the path short
  assign sign_bit = entry_i.is_signed & byte_msbs[top_byte];

  // ------------------------------------------------------------
  // extension
  // ------------------------------------------------------------

  always_comb begin
    case (entry_i.size)
      load_pkg::SIZE_BYTE: result_o = {{(`LOAD_XLEN - 8){sign_bit}}, shifted[7:0]};
      load_pkg::SIZE_HALF: result_o = {{(`LOAD_XLEN - 16){sign_bit}}, shifted[15:0]};
      load_pkg::SIZE_WORD: result_o = {{(`LOAD_XLEN - 32){sign_bit}}, shifted[31:0]};
      // LD uses the whole word as it came back
      default:             result_o = shifted;
    endcase
  end

endmodule

// File: logic/load_buffer.sv
// load_buffer: outstanding load slots with valid and flushed flags, free search and response read
`timescale 1ns/1ps
`include "load_defines.svh"

module load_buffer (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  // allocation on grant
  input  logic                    alloc_i,
  input  load_pkg::ldbuf_id_t     alloc_id_i,
  input  load_pkg::ldbuf_entry_t  alloc_entry_i,
  output logic                    full_o,
  output load_pkg::ldbuf_id_t     free_id_o,
  // read on response
  input  logic                    rvalid_i,
  input  load_pkg::ldbuf_id_t     rid_i,
  output load_pkg::ldbuf_entry_t  rd_entry_o,
  output logic                    rd_live_o
);

  logic [`LOAD_BUF_ENTRIES-1:0] valid_q, valid_d;
  logic [`LOAD_BUF_ENTRIES-1:0] flushed_q, flushed_d;
  load_pkg::ldbuf_entry_t       entry_q [`LOAD_BUF_ENTRIES];

  assign full_o = &valid_q;

  // ------------------------------------------------------------
  // free slot search
  // ------------------------------------------------------------

  // walk down so that the lowest free slot is the last one written
  // only slots free at this edge are candidates, so a slot being released now is skipped
  always_comb begin
    free_id_o = '0;
    for (int i = `LOAD_BUF_ENTRIES - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_id_o = load_pkg::ldbuf_id_t'(i);
      end
    end
  end

  // ------------------------------------------------------------
  // flag update
  // ------------------------------------------------------------

  always_comb begin
    valid_d   = valid_q;
    flushed_d = flushed_q;
    // a flush only hits loads that already hold a slot
    if (flush_i) begin
      flushed_d = flushed_q | valid_q;
    end
    // the response releases its slot at the next edge
    if (rvalid_i) begin
      valid_d[rid_i] = 1'b0;
    end
    // a load granted in the flush cycle is younger than the flush and stays live
    if (alloc_i) begin
      valid_d[alloc_id_i]   = 1'b1;
      flushed_d[alloc_id_i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      entry_q[alloc_id_i] <= alloc_entry_i;
    end
  end

  // ------------------------------------------------------------
  // response read
  // ------------------------------------------------------------

  assign rd_entry_o = entry_q[rid_i];
  // flushed loads are absorbed here, so the top never retires them
  assign rd_live_o  = !flushed_q[rid_i];

  // memory must only answer ids that it was granted and has not yet answered
  a_rid_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |-> valid_q[rid_i])
    else $error("response for a load buffer slot that is not outstanding");
  a_alloc_free : assert property (@(posedge clk_i) disable iff (!rst_ni)
    alloc_i |-> !valid_q[alloc_id_i])
    else $error("allocation into a load buffer slot that is still in use");

endmodule

// File: logic/load_decode.sv
// load_decode: operation to byte enable, transfer size and signedness, with alignment checks
`timescale 1ns/1ps
`include "load_defines.svh"

module load_decode (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  load_pkg::load_op_e            op_i,
  input  logic [`LOAD_OFFSET_BITS-1:0]  offset_i,
  input  logic                          accept_i,
  output logic [`LOAD_XLEN_BYTES-1:0]   be_o,
  output load_pkg::load_size_e          size_o,
  output logic                          is_signed_o
);

  // bytes covered by the access before it is moved to its offset
  logic [`LOAD_XLEN_BYTES-1:0] width_mask;

  // ------------------------------------------------------------
  // size and signedness
  // ------------------------------------------------------------

  always_comb begin
    size_o      = load_pkg::SIZE_BYTE;
    is_signed_o = 1'b0;
    case (op_i)
      load_pkg::LB: begin
        size_o      = load_pkg::SIZE_BYTE;
        is_signed_o = 1'b1;
      end
      load_pkg::LBU: size_o = load_pkg::SIZE_BYTE;
      load_pkg::LH: begin
        size_o      = load_pkg::SIZE_HALF;
        is_signed_o = 1'b1;
      end
      load_pkg::LHU: size_o = load_pkg::SIZE_HALF;
      load_pkg::LW: begin
        size_o      = load_pkg::SIZE_WORD;
        is_signed_o = 1'b1;
      end
      load_pkg::LWU: size_o = load_pkg::SIZE_WORD;
      // a full doubleword fills the register, so it is never extended
      load_pkg::LD: size_o = load_pkg::SIZE_DOUBLE;
      default: begin
        size_o      = load_pkg::SIZE_BYTE;
        is_signed_o = 1'b0;
      end
    endcase
  end

  // ------------------------------------------------------------
  // byte enable
  // ------------------------------------------------------------

  // one bit per accessed byte, starting from byte zero
  always_comb begin
    case (size_o)
      load_pkg::SIZE_BYTE: width_mask = 8'h01;
      load_pkg::SIZE_HALF: width_mask = 8'h03;
      load_pkg::SIZE_WORD: width_mask = 8'h0f;
      default:             width_mask = 8'hff;
    endcase
  end

  // moving the mask up by the offset gives the lanes inside the aligned word
  assign be_o = width_mask << offset_i;

  // misaligned loads are not supported, the issue stage must never send one
  a_half_aligned : assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept_i && (size_o == load_pkg::SIZE_HALF) |-> (offset_i[0] == 1'b0))
    else $error("halfword load at an odd offset");
  a_word_aligned : assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept_i && (size_o == load_pkg::SIZE_WORD) |-> (offset_i[1:0] == 2'b00))
    else $error("word load at an offset that is not a multiple of four");
  a_double_aligned : assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept_i && (size_o == load_pkg::SIZE_DOUBLE) |-> (offset_i == '0))
    else $error("doubleword load at a nonzero offset");

endmodule

// File: logic/load_defines.svh
// width, depth and id size macros for the load unit
`ifndef LOAD_DEFINES_SVH
`define LOAD_DEFINES_SVH

// ------------------------------------------------------------
// data path
// ------------------------------------------------------------

// width of a register and of a memory data word
`define LOAD_XLEN 64
// number of bytes in one data word, also the width of a byte enable
`define LOAD_XLEN_BYTES 8
// byte offset of an address inside the data word
`define LOAD_OFFSET_BITS 3
// physical address width seen by the data memory
`define LOAD_ADDR_WIDTH 32

// ------------------------------------------------------------
// outstanding loads
// ------------------------------------------------------------

// slots in the load buffer, one per outstanding memory request
`define LOAD_BUF_ENTRIES 4
// slot index, which is also the memory request id
`define LOAD_BUF_ID_BITS 2
// scoreboard id carried by every load
`define LOAD_TRANS_ID_BITS 3

`endif

// File: logic/load_issue.sv
// load_issue: request FSM that accepts loads, holds the memory request until grant, allocates slots
`timescale 1ns/1ps
`include "load_defines.svh"

module load_issue (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // issue handshake
  input  logic                          valid_i,
  output logic                          ready_o,
  input  logic [`LOAD_ADDR_WIDTH-1:0]   addr_i,
  input  logic [`LOAD_XLEN_BYTES-1:0]   be_i,
  input  load_pkg::load_size_e          size_i,
  input  load_pkg::ldbuf_entry_t        entry_i,
  // load buffer status
  input  logic                          full_i,
  input  load_pkg::ldbuf_id_t           free_id_i,
  // memory request
  output logic                          mem_req_o,
  input  logic                          mem_gnt_i,
  output logic [`LOAD_ADDR_WIDTH-1:0]   mem_addr_o,
  output logic [`LOAD_XLEN_BYTES-1:0]   mem_be_o,
  output load_pkg::load_size_e          mem_size_o,
  output load_pkg::ldbuf_id_t           mem_id_o,
  // load buffer write
  output logic                          alloc_o,
  output load_pkg::ldbuf_entry_t        alloc_entry_o
);

  typedef enum logic {
    IDLE,
    WAIT_GNT
  } state_e;

  state_e state_q, state_d;
  logic   accept;

  // request fields kept while the grant is pending
  logic [`LOAD_ADDR_WIDTH-1:0] addr_q;
  logic [`LOAD_XLEN_BYTES-1:0] be_q;
  load_pkg::load_size_e        size_q;
  load_pkg::ldbuf_id_t         id_q;
  load_pkg::ldbuf_entry_t      entry_q;

  // a new load only fits when nothing is pending and a slot is free
  assign ready_o = (state_q == IDLE) && !full_i;
  assign accept  = valid_i && ready_o;

  // ------------------------------------------------------------
  // request mux
  // ------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    if (state_q == IDLE) begin
      // the request goes out in the acceptance cycle straight from the inputs
      mem_req_o     = accept;
      mem_addr_o    = {addr_i[`LOAD_ADDR_WIDTH-1:`LOAD_OFFSET_BITS], {`LOAD_OFFSET_BITS{1'b0}}};
      mem_be_o      = be_i;
      mem_size_o    = size_i;
      mem_id_o      = free_id_i;
      alloc_entry_o = entry_i;
      if (accept && !mem_gnt_i) begin
        state_d = WAIT_GNT;
      end
    end else begin
      // replay the registered request until memory takes it
      mem_req_o     = 1'b1;
      mem_addr_o    = addr_q;
      mem_be_o      = be_q;
      mem_size_o    = size_q;
      mem_id_o      = id_q;
      alloc_entry_o = entry_q;
      if (mem_gnt_i) begin
        state_d = IDLE;
      end
    end
  end

  // the slot is claimed in the cycle that the request is transferred
  assign alloc_o = mem_req_o && mem_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // the free slot is captured too, since responses may free lower slots meanwhile
  always_ff @(posedge clk_i) begin
    if ((state_q == IDLE) && accept && !mem_gnt_i) begin
      addr_q  <= mem_addr_o;
      be_q    <= be_i;
      size_q  <= size_i;
      id_q    <= free_id_i;
      entry_q <= entry_i;
    end
  end

  // memory may not see the request change or drop before the grant
  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o) && $stable(mem_be_o)
      && $stable(mem_size_o) && $stable(mem_id_o))
    else $error("memory request changed while waiting for grant");

endmodule

// File: logic/load_pkg.sv
// load operation and transfer size enums, load buffer entry and slot index types
`include "load_defines.svh"

package load_pkg;

  // ------------------------------------------------------------
  // operations
  // ------------------------------------------------------------

  // the integer loads handled by the unit
  // the U variants zero-extend, LD needs no extension at all
  typedef enum logic [2:0] {
    LB  = 3'd0,
    LBU = 3'd1,
    LH  = 3'd2,
    LHU = 3'd3,
    LW  = 3'd4,
    LWU = 3'd5,
    LD  = 3'd6
  } load_op_e;

  // transfer size as log2 of the number of bytes
  // this encoding is what the memory port expects on its size field
  typedef enum logic [1:0] {
    SIZE_BYTE   = 2'd0,
    SIZE_HALF   = 2'd1,
    SIZE_WORD   = 2'd2,
    SIZE_DOUBLE = 2'd3
  } load_size_e;

  // ------------------------------------------------------------
  // load buffer
  // ------------------------------------------------------------

  // what has to be remembered about a load while its response is pending
  // the offset and size are enough to realign, the signed flag picks the extension
  typedef struct packed {
    logic [`LOAD_TRANS_ID_BITS-1:0] trans_id;
    logic [`LOAD_OFFSET_BITS-1:0]   offset;
    load_size_e                     size;
    logic                           is_signed;
  } ldbuf_entry_t;

  // index of a load buffer slot, sent to memory as the request id
  typedef logic [`LOAD_BUF_ID_BITS-1:0] ldbuf_id_t;

endpackage

// File: logic/load_unit.sv
// load_unit: top level joining decode, issue FSM, load buffer and result alignment
`timescale 1ns/1ps
`include "load_defines.svh"

module load_unit (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            flush_i,
  // issue side
  input  logic                            valid_i,
  output logic                            ready_o,
  input  load_pkg::load_op_e              op_i,
  input  logic [`LOAD_ADDR_WIDTH-1:0]     addr_i,
  input  logic [`LOAD_TRANS_ID_BITS-1:0]  trans_id_i,
  // memory request
  output logic                            mem_req_o,
  input  logic                            mem_gnt_i,
  output logic [`LOAD_ADDR_WIDTH-1:0]     mem_addr_o,
  output logic [`LOAD_XLEN_BYTES-1:0]     mem_be_o,
  output load_pkg::load_size_e            mem_size_o,
  output load_pkg::ldbuf_id_t             mem_id_o,
  // memory response
  input  logic                            mem_rvalid_i,
  input  load_pkg::ldbuf_id_t             mem_rid_i,
  input  logic [`LOAD_XLEN-1:0]           mem_rdata_i,
  // result
  output logic                            valid_o,
  output logic [`LOAD_TRANS_ID_BITS-1:0]  trans_id_o,
  output logic [`LOAD_XLEN-1:0]           result_o
);

  logic [`LOAD_XLEN_BYTES-1:0] dec_be;
  load_pkg::load_size_e        dec_size;
  logic                        dec_signed;
  load_pkg::ldbuf_entry_t      new_entry;
  logic                        accept;
  logic                        buf_full;
  load_pkg::ldbuf_id_t         buf_free_id;
  logic                        alloc;
  load_pkg::ldbuf_entry_t      alloc_entry;
  load_pkg::ldbuf_entry_t      rd_entry;
  logic                        rd_live;

  assign accept    = valid_i && ready_o;
  assign new_entry = '{trans_id: trans_id_i, offset: addr_i[`LOAD_OFFSET_BITS-1:0],
                       size: dec_size, is_signed: dec_signed};

  load_decode u_decode (
    .clk_i, .rst_ni, .op_i, .offset_i(addr_i[`LOAD_OFFSET_BITS-1:0]), .accept_i(accept),
    .be_o(dec_be), .size_o(dec_size), .is_signed_o(dec_signed)
  );

  load_issue u_issue (
    .clk_i, .rst_ni, .valid_i, .ready_o, .addr_i, .be_i(dec_be), .size_i(dec_size),
    .entry_i(new_entry), .full_i(buf_full), .free_id_i(buf_free_id),
    .mem_req_o, .mem_gnt_i, .mem_addr_o, .mem_be_o, .mem_size_o, .mem_id_o,
    .alloc_o(alloc), .alloc_entry_o(alloc_entry)
  );

  // the slot written is always the id that memory was granted
  load_buffer u_buffer (
    .clk_i, .rst_ni, .flush_i, .alloc_i(alloc), .alloc_id_i(mem_id_o),
    .alloc_entry_i(alloc_entry), .full_o(buf_full), .free_id_o(buf_free_id),
    .rvalid_i(mem_rvalid_i), .rid_i(mem_rid_i), .rd_entry_o(rd_entry), .rd_live_o(rd_live)
  );

  load_align u_align (
    .rdata_i(mem_rdata_i), .entry_i(rd_entry), .result_o
  );

  // results leave in the response cycle unless the load was flushed
  assign valid_o    = mem_rvalid_i && rd_live;
  assign trans_id_o = rd_entry.trans_id;

endmodule

// File: verif/load_cases.txt
# op addr trans_id mem_word flush expected, all hex
# op: 0 LB, 1 LBU, 2 LH, 3 LHU, 4 LW, 5 LWU, 6 LD; a flushed load never retires
0 80001000 0 f0e1d2c3b4a59687 0 ffffffffffffff87
0 80001009 1 0f1e2d3c4b5a6978 0 0000000000000069
0 80001012 2 f0e1d2c3b4a59687 0 ffffffffffffffa5
0 8000101b 3 0f1e2d3c4b5a6978 0 000000000000004b
0 80001024 4 f0e1d2c3b4a59687 0 ffffffffffffffc3
0 8000102d 5 0f1e2d3c4b5a6978 0 000000000000002d
0 80001036 6 f0e1d2c3b4a59687 0 ffffffffffffffe1
0 8000103f 7 0f1e2d3c4b5a6978 0 000000000000000f
1 80001040 0 f0e1d2c3b4a59687 0 0000000000000087
1 80001049 1 f0e1d2c3b4a59687 0 0000000000000096
1 80001052 2 f0e1d2c3b4a59687 0 00000000000000a5
1 8000105b 3 f0e1d2c3b4a59687 0 00000000000000b4
1 80001064 4 f0e1d2c3b4a59687 0 00000000000000c3
1 8000106d 5 f0e1d2c3b4a59687 0 00000000000000d2
1 80001076 6 f0e1d2c3b4a59687 0 00000000000000e1
1 8000107f 7 f0e1d2c3b4a59687 0 00000000000000f0
2 80001080 0 f0e1d2c3b4a59687 0 ffffffffffff9687
2 8000108a 1 0f1e2d3c4b5a6978 0 0000000000004b5a
2 80001094 2 f0e1d2c3b4a59687 0 ffffffffffffd2c3
2 8000109e 3 0f1e2d3c4b5a6978 0 0000000000000f1e
3 800010a0 4 f0e1d2c3b4a59687 0 0000000000009687
3 800010aa 5 f0e1d2c3b4a59687 0 000000000000b4a5
3 800010b4 6 f0e1d2c3b4a59687 0 000000000000d2c3
3 800010be 7 f0e1d2c3b4a59687 0 000000000000f0e1
4 800010c0 0 f0e1d2c3b4a59687 0 ffffffffb4a59687
4 800010cc 1 0f1e2d3c4b5a6978 0 000000000f1e2d3c
5 800010d0 2 f0e1d2c3b4a59687 0 00000000b4a59687
5 800010dc 3 f0e1d2c3b4a59687 0 00000000f0e1d2c3
6 800010e0 4 f0e1d2c3b4a59687 0 f0e1d2c3b4a59687
0 800010e9 5 f0e1d2c3b4a59687 1 0000000000000000
4 800010f4 6 0f1e2d3c4b5a6978 1 0000000000000000
6 800010f8 7 f0e1d2c3b4a59687 1 0000000000000000
2 80001102 0 f0e1d2c3b4a59687 0 ffffffffffffb4a5
5 8000110c 1 0f1e2d3c4b5a6978 0 000000000f1e2d3c
6 80001110 2 0f1e2d3c4b5a6978 0 0f1e2d3c4b5a6978

// File: verif/load_unit_tb.sv
// load unit testbench with case file reader, memory model with random grant and response order, checks
`timescale 1ns/1ps
`include "load_defines.svh"

module load_unit_tb;

  localparam string cases_file      = "verif/load_cases.txt";
  // responses are withheld from this case on until the buffer has been full for a while
  localparam int    full_start      = 8;
  localparam int    full_hold       = 3;
  localparam int    cycles_per_case = 40;

  logic clk;
  logic rst_n;

  // DUT inputs start quiet
  logic                           flush       = 1'b0;
  logic                           issue_valid = 1'b0;
  load_pkg::load_op_e             issue_op    = load_pkg::LB;
  logic [`LOAD_ADDR_WIDTH-1:0]    issue_addr  = '0;
  logic [`LOAD_TRANS_ID_BITS-1:0] issue_tid   = '0;
  logic                           mem_gnt     = 1'b0;
  logic                           mem_rvalid  = 1'b0;
  load_pkg::ldbuf_id_t            mem_rid     = '0;
  logic [`LOAD_XLEN-1:0]          mem_rdata   = '0;

  logic                           ready;
  logic                           mem_req;
  logic [`LOAD_ADDR_WIDTH-1:0]    mem_addr;
  logic [`LOAD_XLEN_BYTES-1:0]    mem_be;
  load_pkg::load_size_e           mem_size;
  load_pkg::ldbuf_id_t            mem_id;
  logic                           res_valid;
  logic [`LOAD_TRANS_ID_BITS-1:0] res_tid;
  logic [`LOAD_XLEN-1:0]          res_data;

  // one entry per line of the case file
  int          case_op[$];
  logic [31:0] case_addr[$];
  int          case_tid[$];
  logic [63:0] case_word[$];
  int          case_flush[$];
  logic [63:0] case_exp[$];
  int          n_cases = 0;

  // memory model and scoreboard state
  logic [15:0]         lfsr = 16'd96;
  int                  cur_case = 0;
  int                  req_case = 0;
  int                  accepted = 0;
  int                  granted = 0;
  int                  done_cnt = 0;
  int                  outstanding = 0;
  bit                  waiting = 1'b0;
  logic [31:0]         held_addr = '0;
  load_pkg::ldbuf_id_t held_id = '0;
  int                  gnt_delay = 0;
  bit                  hold_rsp = 1'b0;
  bit                  hold_flush = 1'b0;
  int                  full_cycles = 0;
  bit                  rsp_valid = 1'b0;
  load_pkg::ldbuf_id_t rsp_id = '0;
  logic [63:0]         rsp_data = '0;
  int                  pend[$];
  int                  slot_case[`LOAD_BUF_ENTRIES];
  bit                  slot_busy[`LOAD_BUF_ENTRIES];

  tb_clock u_clock (.clk_o(clk), .rst_no(rst_n));

  load_unit dut_i (
    .clk_i(clk), .rst_ni(rst_n), .flush_i(flush),
    .valid_i(issue_valid), .ready_o(ready), .op_i(issue_op), .addr_i(issue_addr),
    .trans_id_i(issue_tid),
    .mem_req_o(mem_req), .mem_gnt_i(mem_gnt), .mem_addr_o(mem_addr), .mem_be_o(mem_be),
    .mem_size_o(mem_size), .mem_id_o(mem_id),
    .mem_rvalid_i(mem_rvalid), .mem_rid_i(mem_rid), .mem_rdata_i(mem_rdata),
    .valid_o(res_valid), .trans_id_o(res_tid), .result_o(res_data)
  );

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      $display("test failed");
      $fatal(1);
    end
  endtask

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // each bit taken costs one LFSR step
  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int b = 0; b < n; b++) begin
      v = (v << 1) | lfsr[15];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // bytes moved by an operation given in the order LB LBU LH LHU LW LWU LD
  function automatic int size_bytes(input int op);
    case (op)
      0, 1: return 1;
      2, 3: return 2;
      4, 5: return 4;
      default: return 8;
    endcase
  endfunction

  function automatic logic [7:0] expected_be(input int op, input logic [2:0] off);
    logic [15:0] mask;
    mask = ((16'd1 << size_bytes(op)) - 16'd1) << off;
    return mask[7:0];
  endfunction

  // ------------------------------------------------------------
  // memory model and checks sampled mid cycle
  // ------------------------------------------------------------

  always @(negedge clk) begin : monitor
    int c;
    int pick;
    if (rst_n) begin
      if (issue_valid && ready) begin
        req_case = cur_case;
        accepted++;
      end
      // a load fits only with no grant pending and a free slot
      check_value("ready_o", !waiting && (outstanding < `LOAD_BUF_ENTRIES), ready);
      // a request that missed its grant comes back unchanged
      if (waiting) begin
        check_value("held mem_req_o", 1, mem_req);
        check_value("held mem_addr_o", held_addr, mem_addr);
        check_value("held mem_id_o", held_id, mem_id);
      end
      if (mem_rvalid) begin
        c = slot_case[mem_rid];
        check_value($sformatf("case %0d valid_o", c), !case_flush[c], res_valid);
        if (!case_flush[c]) begin
          check_value($sformatf("case %0d trans_id_o", c), case_tid[c], res_tid);
          check_value($sformatf("case %0d result_o", c), case_exp[c], res_data);
        end
        slot_busy[mem_rid] = 1'b0;
        done_cnt++;
      end else begin
        check_value("valid_o without response", 0, res_valid);
      end
      if (mem_req && mem_gnt) begin
        c = req_case;
        check_value($sformatf("case %0d mem_addr_o", c), {case_addr[c][31:3], 3'b000}, mem_addr);
        check_value($sformatf("case %0d mem_be_o", c),
                    expected_be(case_op[c], case_addr[c][2:0]), mem_be);
        check_value($sformatf("case %0d mem_size_o", c), $clog2(size_bytes(case_op[c])), mem_size);
        check_value($sformatf("case %0d slot already busy", c), 0, slot_busy[mem_id]);
        slot_case[mem_id] = c;
        slot_busy[mem_id] = 1'b1;
        pend.push_back(mem_id);
        granted++;
        waiting = 1'b0;
        take_bits(2, gnt_delay);
      end else if (mem_req) begin
        waiting = 1'b1;
        held_addr = mem_addr;
        held_id = mem_id;
        if (gnt_delay > 0) gnt_delay--;
      end
      // slots in use after the coming edge
      outstanding = granted - done_cnt;
      if (hold_rsp && (outstanding == `LOAD_BUF_ENTRIES)) begin
        full_cycles++;
        if (full_cycles >= full_hold) begin
          hold_rsp = 1'b0;
        end
      end
      // answer one granted id per cycle at most, picked at random from the queue
      rsp_valid = 1'b0;
      if ((pend.size() > 0) && !hold_rsp && !hold_flush) begin
        take_bits(1, pick);
        if (pick == 1) begin
          take_bits(2, pick);
          pick = pick % pend.size();
          rsp_id = load_pkg::ldbuf_id_t'(pend[pick]);
          rsp_data = case_word[slot_case[pend[pick]]];
          pend.delete(pick);
          rsp_valid = 1'b1;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      mem_gnt    <= (gnt_delay == 0);
      mem_rvalid <= rsp_valid;
      mem_rid    <= rsp_id;
      mem_rdata  <= rsp_data;
    end
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------

  // wait until every load of the group holds a slot, then flush them all
  task automatic pulse_flush(input int upto);
    issue_valid <= 1'b0;
    while (granted != upto) @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    hold_flush = 1'b0;
  endtask

  initial begin : stimulus
    int          fd;
    string       line;
    int          op;
    logic [31:0] addr;
    int          tid;
    logic [63:0] word;
    int          fl;
    logic [63:0] exp;
    fd = $fopen(cases_file, "r");
    if (fd == 0) begin
      $display("could not open the case file %s", cases_file);
      $display("test failed");
      $fatal(1);
    end
    while ($fgets(line, fd) > 0) begin
      if ((line[0] != "#") &&
          ($sscanf(line, "%h %h %h %h %h %h", op, addr, tid, word, fl, exp) == 6)) begin
        case_op.push_back(op);
        case_addr.push_back(addr);
        case_tid.push_back(tid);
        case_word.push_back(word);
        case_flush.push_back(fl);
        case_exp.push_back(exp);
      end
    end
    $fclose(fd);
    n_cases = case_op.size();
    if (n_cases == 0) begin
      $display("the case file holds no loads");
      $display("test failed");
      $fatal(1);
    end
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_value("ready_o after reset", 1, ready);
    check_value("mem_req_o after reset", 0, mem_req);
    check_value("valid_o after reset", 0, res_valid);
    @(posedge clk);
    for (int i = 0; i < n_cases; i++) begin
      if ((i > 0) && case_flush[i-1] && !case_flush[i]) pulse_flush(i);
      // a flush group starts from an empty buffer and keeps its responses back
      if (case_flush[i] && ((i == 0) || !case_flush[i-1])) begin
        issue_valid <= 1'b0;
        while (done_cnt != i) @(posedge clk);
        hold_flush = 1'b1;
      end
      if (i == full_start) hold_rsp = 1'b1;
      issue_valid <= 1'b1;
      issue_op    <= load_pkg::load_op_e'(case_op[i]);
      issue_addr  <= case_addr[i];
      issue_tid   <= case_tid[i];
      cur_case    <= i;
      do @(posedge clk); while (accepted != i + 1);
    end
    if (case_flush[n_cases-1]) pulse_flush(n_cases);
    issue_valid <= 1'b0;
    while (done_cnt != n_cases) @(posedge clk);
    $display("test passed");
    $finish;
  end

  initial begin : watchdog
    wait (n_cases > 0);
    repeat (cycles_per_case * n_cases) @(posedge clk);
    $display("timeout: the loads did not complete within %0d cycles", cycles_per_case * n_cases);
    $display("test failed");
    $fatal(1);
  end

endmodule

// File: verif/tb_clock.sv
// clock and reset generator for the load unit testbench
`timescale 1ns/1ps

module tb_clock #(
  parameter int period_ns    = 20,
  parameter int reset_cycles = 4
) (
  output logic clk_o,
  output logic rst_no
);

  // free running clock, the first rising edge comes half a period in
  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  // reset is released on a rising edge, like any other driven input
  initial begin
    rst_no = 1'b0;
    repeat (reset_cycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule
